// File: imul_unit.f
+incdir+.
imul_pkg.sv
imul_req_prep.sv
imul_req_fifo.sv
imul_iter_ctrl.sv
imul_iter_dpath.sv
imul_unit.sv
tb_imul_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f imul_unit.f --top-module tb_imul_unit -o tb_imul_unit \
  && ./obj_dir/tb_imul_unit > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Regression failed" sim.log && exit 1 || exit 0

// File: tb_imul_unit.sv
/*
 * testbench for the iterative multiply unit
 * reference multiply, val/rdy stimulus and in-order response compare
 */

`timescale 1ns/10ps

`include "imul_cfg.svh"

module tb_imul_unit
  import imul_pkg::*;
;

  localparam int REQ_TIMEOUT = 1000;

  logic     clk;
  logic     reset;
  mul_req_t req_msg;
  logic     req_val;
  logic     req_rdy;
  product_t resp_msg;
  logic     resp_val;
  logic     resp_rdy;

  // expected products in request order
  product_t exp_q[$];
  operand_t corner [5];
  string    cur_test;
  int       errors;
  int       sent;
  int       resp_count;
  int       test_start;
  int       sent_start;
  int       resp_start;
  logic     rdy_random;
  logic     saw_stall;
  logic     hold_pending;
  product_t hold_value;

  imul_unit dut_i (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // ------------------------------
  // reference and checks
  // ------------------------------

  // signed product from sign-extended operands
  function automatic product_t ref_mul(input operand_t a, input operand_t b);
    longint sa;
    longint sb;
    sa = longint'($signed(a));
    sb = longint'($signed(b));
    return product_t'(sa * sb);
  endfunction

  task automatic check_product(input string name, input product_t exp, input product_t act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-9s %0d requests, %0d errors", name, sent - sent_start, errors - test_start);
  endtask

  task automatic start_test(input string name);
    cur_test   = name;
    test_start = errors;
    sent_start = sent;
    resp_start = resp_count;
  endtask

  // ------------------------------
  // stimulus helpers
  // ------------------------------

  // advance to the next falling edge and reshuffle resp_rdy when back-pressure is on
  task automatic next_cycle();
    @(negedge clk);
    if (rdy_random) begin
      resp_rdy = ($urandom % 2) == 1;
    end
  endtask

  // offer a request and leave req_val high once it has gone in
  task automatic send_req(input operand_t a, input operand_t b);
    int waited;
    waited      = 0;
    req_msg.a   = a;
    req_msg.b   = b;
    req_val     = 1'b1;
    if (!req_rdy) begin
      saw_stall = 1'b1;
    end
    while (!req_rdy && waited < REQ_TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (!req_rdy) begin
      errors++;
      $display("%s: request was never accepted, req_rdy stayed low", cur_test);
    end else begin
      exp_q.push_back(ref_mul(a, b));
      sent++;
    end
    // transfer happens on the rising edge in between
    next_cycle();
  endtask

  // wait until every expected product has come back
  task automatic wait_drain();
    int waited;
    int limit;
    req_val = 1'b0;
    waited  = 0;
    limit   = 200 + 150 * exp_q.size();
    while (exp_q.size() != 0 && waited < limit) begin
      next_cycle();
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("%s: %0d responses never arrived", cur_test, exp_q.size());
    end
  endtask

  // ------------------------------
  // response compare
  // ------------------------------

  always @(posedge clk) begin
    if (reset) begin
      hold_pending = 1'b0;
    end else begin
      // stalled response must stay offered and unchanged
      if (hold_pending) begin
        check_flag({cur_test, " hold resp_val"}, 1'b1, resp_val);
        check_product({cur_test, " hold"}, hold_value, resp_msg);
      end
      if (resp_val && resp_rdy) begin
        resp_count++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("%s: response arrived with no request outstanding", cur_test);
        end else begin
          check_product(cur_test, exp_q.pop_front(), resp_msg);
        end
      end
      hold_pending = resp_val && !resp_rdy;
      hold_value   = resp_msg;
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    void'($urandom(17));
    clk          = 1'b0;
    reset        = 1'b1;
    req_msg      = '0;
    req_val      = 1'b0;
    resp_rdy     = 1'b1;
    rdy_random   = 1'b0;
    saw_stall    = 1'b0;
    hold_pending = 1'b0;
    hold_value   = '0;
    errors       = 0;
    sent         = 0;
    resp_count   = 0;
    corner[0]    = '0;
    corner[1]    = operand_t'(1);
    corner[2]    = '1;
    corner[3]    = {1'b0, {(`IMUL_WIDTH-1){1'b1}}};
    corner[4]    = {1'b1, {(`IMUL_WIDTH-1){1'b0}}};

    // reset held for three rising edges
    start_test("reset");
    @(negedge clk);
    check_flag("reset resp_val", 1'b0, resp_val);
    check_flag("reset req_rdy", 1'b1, req_rdy);
    repeat (2) @(negedge clk);
    reset = 1'b0;
    next_cycle();
    check_flag("after reset resp_val", 1'b0, resp_val);
    check_flag("after reset req_rdy", 1'b1, req_rdy);
    report_test("reset");

    // every pairing of the corner values with one request in flight
    start_test("corner");
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        send_req(corner[i], corner[j]);
        wait_drain();
      end
    end
    report_test("corner");

    // back to back random pairs
    start_test("random");
    for (int k = 0; k < 200; k++) begin
      send_req(operand_t'($urandom), operand_t'($urandom));
    end
    wait_drain();
    report_test("random");

    // flooding the buffer has to drop req_rdy
    start_test("burst");
    saw_stall = 1'b0;
    for (int k = 0; k < 24; k++) begin
      send_req(operand_t'($urandom), operand_t'($urandom));
    end
    wait_drain();
    check_flag("burst req_rdy stall", 1'b1, saw_stall);
    if (resp_count - resp_start != sent - sent_start) begin
      errors++;
      $display("burst: %0d responses for %0d requests", resp_count - resp_start,
               sent - sent_start);
    end
    report_test("burst");

    // random resp_rdy
    start_test("backpres");
    rdy_random = 1'b1;
    for (int k = 0; k < 40; k++) begin
      send_req(operand_t'($urandom), operand_t'($urandom));
    end
    wait_drain();
    rdy_random = 1'b0;
    resp_rdy   = 1'b1;
    report_test("backpres");

    // reset in the middle of a multiply
    start_test("midreset");
    send_req(operand_t'($urandom), operand_t'($urandom));
    req_val = 1'b0;
    repeat (10) next_cycle();
    check_flag("busy resp_val", 1'b0, resp_val);
    reset = 1'b1;
    exp_q.delete();
    repeat (3) next_cycle();
    reset = 1'b0;
    check_flag("midreset resp_val", 1'b0, resp_val);
    send_req(corner[4], operand_t'(32'h1234_5678));
    wait_drain();
    report_test("midreset");

    $display("summary: %0d requests, %0d responses, %0d errors", sent, resp_count, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: imul_unit.sv
/*
 * signed 32x32 iterative multiply unit
 * prep stage, job buffer and shift-and-add core behind val/rdy ports
 */

`timescale 1ns/10ps

module imul_unit
  import imul_pkg::*;
(
  input  logic     clk,
  input  logic     reset,

  // request side
  input  mul_req_t req_msg,
  input  logic     req_val,
  output logic     req_rdy,

  // response side
  output product_t resp_msg,
  output logic     resp_val,
  input  logic     resp_rdy
);

  mul_job_t      job_msg;
  logic          job_val;
  logic          job_rdy;
  mul_job_t      head_msg;
  logic          head_val;
  logic          head_rdy;
  dpath_ctrl_t   ctrl;
  dpath_status_t status;

  // ------------------------------
  // producer and buffer
  // ------------------------------

  imul_req_prep prep_i (
    .clk     (clk),
    .reset   (reset),
    .req_msg (req_msg),
    .req_val (req_val),
    .req_rdy (req_rdy),
    .job_msg (job_msg),
    .job_val (job_val),
    .job_rdy (job_rdy)
  );

  imul_req_fifo fifo_i (
    .clk     (clk),
    .reset   (reset),
    .in_msg  (job_msg),
    .in_val  (job_val),
    .in_rdy  (job_rdy),
    .out_msg (head_msg),
    .out_val (head_val),
    .out_rdy (head_rdy)
  );

  // ------------------------------
  // iterative core
  // ------------------------------

  imul_iter_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .head_val (head_val),
    .head_rdy (head_rdy),
    .status   (status),
    .ctrl     (ctrl),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // datapath samples the head job on load
  imul_iter_dpath dpath_i (
    .clk    (clk),
    .reset  (reset),
    .job    (head_msg),
    .ctrl   (ctrl),
    .status (status),
    .result (resp_msg)
  );

endmodule

// File: imul_iter_dpath.sv
/*
 * iterative multiply datapath
 * shift-and-add on magnitudes with a final sign correction
 */

`timescale 1ns/10ps

module imul_iter_dpath
  import imul_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  // prepared job at the buffer head
  input  mul_job_t      job,

  // control in, status out
  input  dpath_ctrl_t   ctrl,
  output dpath_status_t status,

  output product_t      result
);

  // iterations after the load, one per operand bit
  localparam count_t LAST_COUNT = count_t'($bits(operand_t) - 1);

  product_t mcand_q;
  operand_t mplier_q;
  count_t   count_q;
  product_t acc_q;
  logic     negate_q;

  product_t mcand_init;
  product_t acc_sum;
  product_t acc_neg;

  // ------------------------------
  // combinational helpers
  // ------------------------------

  // multiplicand zero-extended into the product width
  assign mcand_init = product_t'(job.mag_a);

  // partial product added when the current multiplier bit is set
  assign acc_sum = acc_q + mcand_q;

  // two's complement of the magnitude product
  assign acc_neg = ~acc_q + product_t'(1);

  // ------------------------------
  // status and result
  // ------------------------------

  assign status.b_lsb      = mplier_q[0];
  assign status.count_zero = (count_q == '0);

  // nothing moves in DONE, so this holds steady there
  assign result = negate_q ? acc_neg : acc_q;

  // ------------------------------
  // iteration counter
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else if (ctrl.load) begin
      count_q <= LAST_COUNT;
    end else if (ctrl.step) begin
      count_q <= count_q - count_t'(1);
    end
  end

  // ------------------------------
  // operand and product registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      mcand_q  <= mcand_init;
      mplier_q <= job.mag_b;
      negate_q <= job.negate;
    end else if (ctrl.step) begin
      // multiplicand climbs one weight, multiplier bit consumed
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // accumulator
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      acc_q <= '0;
    end else if (ctrl.step && ctrl.add) begin
      acc_q <= acc_sum;
    end
  end

endmodule

// File: imul_iter_ctrl.sv
/*
 * iterative multiply control
 * IDLE/CALC/DONE FSM stepping the datapath and offering the response
 */

`timescale 1ns/10ps

module imul_iter_ctrl
  import imul_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  // job buffer head
  input  logic          head_val,
  output logic          head_rdy,

  // datapath
  input  dpath_status_t status,
  output dpath_ctrl_t   ctrl,

  // response handshake
  output logic          resp_val,
  input  logic          resp_rdy
);

  mul_state_e state_q;
  mul_state_e state_d;
  logic       job_fire;
  logic       resp_fire;

  // ------------------------------
  // handshake events
  // ------------------------------

  // head_rdy only depends on state, so no path back to head_val
  assign head_rdy  = (state_q == IDLE);
  assign resp_val  = (state_q == DONE);
  assign job_fire  = head_val && head_rdy;
  assign resp_fire = resp_val && resp_rdy;

  // ------------------------------
  // next state and datapath control
  // ------------------------------

  always_comb begin
    state_d = state_q;
    ctrl    = '0;
    case (state_q)
      IDLE: begin
        // load operands, clear accumulator, counter to 31
        if (job_fire) begin
          ctrl.load = 1'b1;
          state_d   = CALC;
        end
      end
      CALC: begin
        // one bit of the multiplier per cycle
        ctrl.step = 1'b1;
        ctrl.add  = status.b_lsb;
        // last step is the one taken with the counter at zero
        if (status.count_zero) begin
          state_d = DONE;
        end
      end
      DONE: begin
        // result held until the consumer takes it
        if (resp_fire) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // ------------------------------
  // state register
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: imul_req_fifo.sv
/*
 * prepared job buffer
 * circular synchronous FIFO with val/rdy on both sides
 */

`timescale 1ns/10ps

`include "imul_cfg.svh"

module imul_req_fifo
  import imul_pkg::*;
#(
  parameter int DEPTH = `IMUL_FIFO_DEPTH
) (
  input  logic     clk,
  input  logic     reset,

  // write side
  input  mul_job_t in_msg,
  input  logic     in_val,
  output logic     in_rdy,

  // read side
  output mul_job_t out_msg,
  output logic     out_val,
  input  logic     out_rdy
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  mul_job_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] occ;
  logic             full;
  logic             empty;
  logic             wr_en;
  logic             rd_en;

  // pointer advance with wrap at DEPTH
  // DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    logic [PTR_W-1:0] n;
    if (p == PTR_W'(DEPTH - 1)) begin
      n = '0;
    end else begin
      n = p + PTR_W'(1);
    end
    return n;
  endfunction

  // ------------------------------
  // status and handshake
  // ------------------------------

  assign full  = (occ == CNT_W'(DEPTH));
  assign empty = (occ == '0);

  assign out_val = !empty;
  assign out_msg = mem[rd_ptr];

  // when full, a write still goes in if the head leaves this cycle
  assign in_rdy = !full || out_rdy;

  assign wr_en = in_val && in_rdy;
  assign rd_en = out_val && out_rdy;

  // ------------------------------
  // storage
  // ------------------------------

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_msg;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // simultaneous write and read leaves the count alone
      case ({wr_en, rd_en})
        2'b10:   occ <= occ + CNT_W'(1);
        2'b01:   occ <= occ - CNT_W'(1);
        default: occ <= occ;
      endcase
    end
  end

endmodule

// File: imul_req_prep.sv
/*
 * multiply request prep stage
 * one-entry register turning signed operands into magnitudes and a sign flag
 */

`timescale 1ns/10ps

module imul_req_prep
  import imul_pkg::*;
(
  input  logic     clk,
  input  logic     reset,

  // request side
  input  mul_req_t req_msg,
  input  logic     req_val,
  output logic     req_rdy,

  // prepared job toward the buffer
  output mul_job_t job_msg,
  output logic     job_val,
  input  logic     job_rdy
);

  logic     req_fire;
  logic     sign_a;
  logic     sign_b;
  mul_job_t job_next;

  // two's complement magnitude
  // the most negative value maps onto its unsigned twin, which is still exact
  function automatic operand_t magnitude(input operand_t v);
    operand_t m;
    if (v[$bits(operand_t)-1]) begin
      m = ~v + operand_t'(1);
    end else begin
      m = v;
    end
    return m;
  endfunction

  // ------------------------------
  // handshake
  // ------------------------------

  // slot free, or the held job leaves this same cycle
  assign req_rdy  = !job_val || job_rdy;
  assign req_fire = req_val && req_rdy;

  // ------------------------------
  // operand conversion
  // ------------------------------

  assign sign_a = req_msg.a[$bits(operand_t)-1];
  assign sign_b = req_msg.b[$bits(operand_t)-1];

  always_comb begin
    job_next.mag_a  = magnitude(req_msg.a);
    job_next.mag_b  = magnitude(req_msg.b);
    // product is negative when exactly one operand is
    job_next.negate = sign_a ^ sign_b;
  end

  // ------------------------------
  // slot registers
  // ------------------------------

  // valid bit of the slot
  always_ff @(posedge clk) begin
    if (reset) begin
      job_val <= 1'b0;
    end else if (req_fire) begin
      job_val <= 1'b1;
    end else if (job_rdy) begin
      job_val <= 1'b0;
    end
  end

  // payload, only written on an accepted request
  always_ff @(posedge clk) begin
    if (req_fire) begin
      job_msg <= job_next;
    end
  end

endmodule

// File: imul_pkg.sv
/*
 * iterative multiply unit types
 * message, job, datapath control/status and FSM state types
 */

`include "imul_cfg.svh"

package imul_pkg;

  // ------------------------------
  // plain vectors
  // ------------------------------

  typedef logic [`IMUL_WIDTH-1:0]   operand_t;
  typedef logic [2*`IMUL_WIDTH-1:0] product_t;
  // iterations left in the current multiply
  typedef logic [`IMUL_CNT_W-1:0]   count_t;

  // ------------------------------
  // messages
  // ------------------------------

  // request message, two signed operands
  typedef struct packed {
    operand_t a;
    operand_t b;
  } mul_req_t;

  // prepared job, unsigned magnitudes plus product sign
  typedef struct packed {
    operand_t mag_a;
    operand_t mag_b;
    logic     negate;
  } mul_job_t;

  // ------------------------------
  // control <-> datapath
  // ------------------------------

  typedef struct packed {
    logic load;
    logic step;
    logic add;
  } dpath_ctrl_t;

  typedef struct packed {
    logic b_lsb;
    logic count_zero;
  } dpath_status_t;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } mul_state_e;

endpackage

// File: imul_cfg.svh
/*
 * iterative multiply unit configuration
 * sizes shared by the package, the job buffer and the testbench
 */

`ifndef IMUL_CFG_SVH
`define IMUL_CFG_SVH

// operand width in bits, the product is twice this
`define IMUL_WIDTH 32

// iteration counter width
// must hold IMUL_WIDTH-1
`define IMUL_CNT_W 5

// number of prepared jobs the buffer can hold
`define IMUL_FIFO_DEPTH 4

`endif
